// ==== rtl/st_capture_cfg.svh ====
`ifndef ST_CAPTURE_CFG_SVH
`define ST_CAPTURE_CFG_SVH

// stream beat geometry
`define ST_SYMBOL_W       8
`define ST_NUM_SYMBOLS    4
`define ST_CHANNEL_W      8
`define ST_ERROR_W        4
`define ST_EMPTY_W        2

// idle counter width, saturates at all ones
`define ST_IDLE_W         16

// sink ready latency, 0 or 1 only
`define ST_READY_LATENCY  0

// transaction queue sizing and back-pressure hysteresis
`define TXN_DEPTH         16
`define TXN_LEVEL_W       ($clog2(`TXN_DEPTH) + 1)
`define TXN_HI_MARK       (`TXN_DEPTH - 3)
`define TXN_LO_MARK       (`TXN_DEPTH / 2)

// apb register space
`define APB_ADDR_W        8

`endif

// ==== rtl/st_stream_pkg.sv ====
`include "st_capture_cfg.svh"

package st_stream_pkg;

   // ------------------------------------------------
   // beat payload
   // ------------------------------------------------

   // one symbol of the data word
   typedef logic [`ST_SYMBOL_W-1:0] st_symbol_t;

   // symbol 0 sits in the low byte
   typedef st_symbol_t [`ST_NUM_SYMBOLS-1:0] st_data_t;

   // ------------------------------------------------
   // transaction header
   // ------------------------------------------------

   // capture side view, 16 + 8 + 4 + 2 + 1 + 1 bits
   typedef struct packed {
      logic [`ST_IDLE_W-1:0]    idles;
      logic [`ST_CHANNEL_W-1:0] channel;
      logic [`ST_ERROR_W-1:0]   error;
      logic [`ST_EMPTY_W-1:0]   empty;
      logic                     sop;
      logic                     eop;
   } st_hdr_fields_t;

   // written through fields, read back over apb as raw
   typedef union packed {
      st_hdr_fields_t fields;
      logic [31:0]    raw;
   } st_header_u;

   // one queue entry, data in the upper word
   typedef struct packed {
      st_data_t   data;
      st_header_u header;
   } st_txn_t;

endpackage

// ==== rtl/st_apb_pkg.sv ====
`include "st_capture_cfg.svh"

package st_apb_pkg;

   // register offsets
   typedef enum logic [`APB_ADDR_W-1:0] {
      REG_CTRL   = 'h00,
      REG_STATUS = 'h04,
      REG_DATA   = 'h08,
      REG_HEADER = 'h0C,
      REG_POP    = 'h10
   } st_reg_e;

   // control word, only bit 0 is implemented
   typedef struct packed {
      logic [30:0] rsvd;
      logic        ready_en;
   } st_ctrl_t;

   // status word
   // level in the low bits, then empty, then full
   typedef struct packed {
      logic [29-`TXN_LEVEL_W:0] rsvd;
      logic                     full;
      logic                     empty;
      logic [`TXN_LEVEL_W-1:0]  level;
   } st_status_t;

endpackage

// ==== rtl/st_txn_if.sv ====
`include "st_capture_cfg.svh"

// queue bookkeeping shared between the data path and its two controllers
interface st_txn_if;

   // number of stored records, 0 to TXN_DEPTH
   logic [`TXN_LEVEL_W-1:0] level;

   // flags derived from level by the queue
   logic empty;
   logic full;

   // write strobe from the ready fsm
   logic push;

   // head removal strobe from the apb side
   logic pop;

   modport queue (output level, empty, full, input push, pop);

   modport fsm (input level, output push);

   modport regs (input level, empty, output pop);

endinterface

// ==== rtl/st_ready_fsm.sv ====
`include "st_capture_cfg.svh"

module st_ready_fsm (
   input  logic    clk,
   input  logic    reset,
   input  logic    ready_en,
   input  logic    sink_valid,
   output logic    sink_ready,
   output logic    accept,
   output logic    qual_ready,
   st_txn_if.fsm   txn
);

   typedef enum logic [1:0] {
      S_OFF,
      S_OPEN,
      S_HOLD
   } state_e;

   state_e state;
   state_e state_nxt;

   // sink_ready from one cycle back, used for latency 1
   logic ready_d;

   // ------------------------------------------------
   // ready control
   // ------------------------------------------------

   always_comb begin
      state_nxt = state;
      case (state)
         S_OFF: begin
            // stay closed while the queue is still above the low mark
            if (ready_en) begin
               state_nxt = (txn.level > `TXN_LO_MARK) ? S_HOLD : S_OPEN;
            end
         end
         S_OPEN: begin
            if (!ready_en) begin
               state_nxt = S_OFF;
            end else if (txn.level >= `TXN_HI_MARK) begin
               state_nxt = S_HOLD;
            end
         end
         S_HOLD: begin
            // hysteresis, reopen only once drained to the low mark
            if (!ready_en) begin
               state_nxt = S_OFF;
            end else if (txn.level <= `TXN_LO_MARK) begin
               state_nxt = S_OPEN;
            end
         end
         default: state_nxt = S_OFF;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= S_OFF;
      end else begin
         state <= state_nxt;
      end
   end

   // ready is a decode of the state register
   assign sink_ready = (state == S_OPEN);

   // ------------------------------------------------
   // latency delay line and acceptance
   // ------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_d <= 1'b0;
      end else begin
         ready_d <= sink_ready;
      end
   end

   assign qual_ready = (`ST_READY_LATENCY == 0) ? sink_ready : ready_d;

   // the only place a beat is taken
   assign accept   = sink_valid & qual_ready;
   assign txn.push = accept;

   // the hi mark margin must absorb the beats still in flight
   a_no_push_full: assert property (
      @(posedge clk) disable iff (reset)
      txn.push |-> (txn.level < `TXN_DEPTH)
   );

endmodule

// ==== rtl/st_idle_counter.sv ====
`include "st_capture_cfg.svh"

module st_idle_counter (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  qual_ready,
   input  logic                  sink_valid,
   input  logic                  accept,
   output logic [`ST_IDLE_W-1:0] idles
);

   logic [`ST_IDLE_W-1:0] count;

   // sink was ready but nothing offered
   logic idle_cycle;

   assign idle_cycle = qual_ready & ~sink_valid;

   // accept needs sink_valid high and an idle cycle needs it low
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         count <= '0;
      end else if (accept) begin
         count <= '0;
      end else if (idle_cycle && (count != '1)) begin
         count <= count + 1'b1;
      end
   end

   // value before the clear belongs to the beat being accepted
   assign idles = count;

   // the clear only stands for a beat the sink really took
   a_accept_qual: assert property (
      @(posedge clk) disable iff (reset)
      accept |-> (qual_ready && sink_valid)
   );

endmodule

// ==== rtl/st_txn_queue.sv ====
`include "st_capture_cfg.svh"

module st_txn_queue
   import st_stream_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  st_data_t                 sink_data,
   input  logic [`ST_CHANNEL_W-1:0] sink_channel,
   input  logic [`ST_ERROR_W-1:0]   sink_error,
   input  logic [`ST_EMPTY_W-1:0]   sink_empty,
   input  logic                     sink_startofpacket,
   input  logic                     sink_endofpacket,
   input  logic [`ST_IDLE_W-1:0]    idles,
   output st_txn_t                  head,
   st_txn_if.queue                  txn
);

   localparam int PTR_W = $clog2(`TXN_DEPTH);

   // circular buffer storage
   st_txn_t mem [`TXN_DEPTH];

   logic [PTR_W-1:0]        wr_ptr;
   logic [PTR_W-1:0]        rd_ptr;
   logic [`TXN_LEVEL_W-1:0] level;

   // record under construction from the current beat
   st_txn_t rec;

   // ------------------------------------------------
   // record assembly
   // ------------------------------------------------

   always_comb begin
      rec                       = '0;
      rec.data                  = sink_data;
      rec.header.fields.idles   = idles;
      rec.header.fields.channel = sink_channel;
      rec.header.fields.error   = sink_error;
      rec.header.fields.empty   = sink_empty;
      rec.header.fields.sop     = sink_startofpacket;
      rec.header.fields.eop     = sink_endofpacket;
   end

   // ------------------------------------------------
   // storage and pointers
   // ------------------------------------------------

   // push is already qualified by the fsm
   always_ff @(posedge clk) begin
      if (txn.push) begin
         mem[wr_ptr] <= rec;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (txn.push) begin
            wr_ptr <= (wr_ptr == PTR_W'(`TXN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (txn.pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`TXN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leave the level alone
         case ({txn.push, txn.pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   // head is a plain read of the oldest slot
   assign head = mem[rd_ptr];

   assign txn.level = level;
   assign txn.empty = (level == '0);
   assign txn.full  = (level == `TXN_LEVEL_W'(`TXN_DEPTH));

   a_no_pop_empty: assert property (
      @(posedge clk) disable iff (reset)
      txn.pop |-> !txn.empty
   );

   a_no_push_full: assert property (
      @(posedge clk) disable iff (reset)
      txn.push |-> !txn.full
   );

endmodule

// ==== rtl/st_apb_regs.sv ====
`include "st_capture_cfg.svh"

module st_apb_regs
   import st_stream_pkg::*;
   import st_apb_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`APB_ADDR_W-1:0] paddr,
   input  logic [31:0]            pwdata,
   input  st_txn_t                head,
   output logic [31:0]            prdata,
   output logic                   pready,
   output logic                   pslverr,
   output logic                   ready_en,
   st_txn_if.regs                 txn
);

   st_reg_e    reg_sel;
   st_ctrl_t   ctrl;
   st_status_t status;

   // second phase of the transfer
   logic access;

   // decode results
   logic        addr_ok;
   logic        wr_ok;
   logic [31:0] rd_word;

   assign access  = psel & penable;
   assign reg_sel = st_reg_e'(paddr);

   // ------------------------------------------------
   // status word
   // ------------------------------------------------

   always_comb begin
      status       = '0;
      status.level = txn.level;
      status.empty = txn.empty;
      status.full  = (txn.level == `TXN_LEVEL_W'(`TXN_DEPTH));
   end

   // ------------------------------------------------
   // address decode
   // ------------------------------------------------

   always_comb begin
      rd_word = '0;
      addr_ok = 1'b1;
      wr_ok   = 1'b0;
      case (reg_sel)
         REG_CTRL: begin
            rd_word = ctrl;
            wr_ok   = 1'b1;
         end
         REG_STATUS: rd_word = status;
         // an empty queue reads back as zero
         REG_DATA:   rd_word = txn.empty ? '0 : head.data;
         REG_HEADER: rd_word = txn.empty ? '0 : head.header.raw;
         // pop reads as zero, a write is only legal with data present
         REG_POP:    wr_ok = !txn.empty;
         default:    addr_ok = 1'b0;
      endcase
   end

   // ------------------------------------------------
   // control register
   // ------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ctrl <= '0;
      end else if (access && pwrite && (reg_sel == REG_CTRL)) begin
         ctrl.ready_en <= pwdata[0];
      end
   end

   assign ready_en = ctrl.ready_en;

   // pop takes effect at the access edge
   assign txn.pop = access & pwrite & (reg_sel == REG_POP) & !txn.empty;

   // ------------------------------------------------
   // apb response
   // ------------------------------------------------

   // no wait states
   assign pready = access;

   assign pslverr = access & (!addr_ok | (pwrite & !wr_ok));

   assign prdata = (access && !pwrite && addr_ok) ? rd_word : '0;

   a_penable_psel: assert property (
      @(posedge clk) disable iff (reset)
      penable |-> psel
   );

endmodule

// ==== rtl/st_capture_top.sv ====
`include "st_capture_cfg.svh"

module st_capture_top
   import st_stream_pkg::*;
(
   input  logic                                    clk,
   input  logic                                    reset,
   // avalon-st sink
   input  logic [`ST_SYMBOL_W*`ST_NUM_SYMBOLS-1:0] sink_data,
   input  logic [`ST_CHANNEL_W-1:0]                sink_channel,
   input  logic                                    sink_valid,
   input  logic                                    sink_startofpacket,
   input  logic                                    sink_endofpacket,
   input  logic [`ST_ERROR_W-1:0]                  sink_error,
   input  logic [`ST_EMPTY_W-1:0]                  sink_empty,
   output logic                                    sink_ready,
   // apb slave
   input  logic                                    psel,
   input  logic                                    penable,
   input  logic                                    pwrite,
   input  logic [`APB_ADDR_W-1:0]                  paddr,
   input  logic [31:0]                             pwdata,
   output logic [31:0]                             prdata,
   output logic                                    pready,
   output logic                                    pslverr
);

   st_txn_if txn ();

   logic                  ready_en;
   logic                  accept;
   logic                  qual_ready;
   logic [`ST_IDLE_W-1:0] idles;
   st_txn_t               head;

   // ready control and beat acceptance
   st_ready_fsm i_ready_fsm (
      .clk        (clk),
      .reset      (reset),
      .ready_en   (ready_en),
      .sink_valid (sink_valid),
      .sink_ready (sink_ready),
      .accept     (accept),
      .qual_ready (qual_ready),
      .txn        (txn.fsm)
   );

   st_idle_counter i_idle_counter (
      .clk        (clk),
      .reset      (reset),
      .qual_ready (qual_ready),
      .sink_valid (sink_valid),
      .accept     (accept),
      .idles      (idles)
   );

   st_txn_queue i_txn_queue (
      .clk                (clk),
      .reset              (reset),
      .sink_data          (sink_data),
      .sink_channel       (sink_channel),
      .sink_error         (sink_error),
      .sink_empty         (sink_empty),
      .sink_startofpacket (sink_startofpacket),
      .sink_endofpacket   (sink_endofpacket),
      .idles              (idles),
      .head               (head),
      .txn                (txn.queue)
   );

   // software view of the queue
   st_apb_regs i_apb_regs (
      .clk      (clk),
      .reset    (reset),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .head     (head),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .ready_en (ready_en),
      .txn      (txn.regs)
   );

endmodule

// ==== sim/st_capture_tb.sv ====
`include "st_capture_cfg.svh"

module st_capture_tb
   import st_stream_pkg::*;
   import st_apb_pkg::*;
;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_BEATS  = 63;
   localparam int MAX_GAP    = 3;
   localparam int APB_XFERS  = 220;
   // beats at their longest spacing plus three cycles per apb transfer and the reset
   // scaled by a margin of 4
   localparam int WATCHDOG_LIMIT = 4 * (NUM_BEATS * (MAX_GAP + 1) * CLK_PERIOD
                                        + APB_XFERS * 3 * CLK_PERIOD + 8 * CLK_PERIOD);

   logic                                    clk;
   logic                                    reset;
   logic [`ST_SYMBOL_W*`ST_NUM_SYMBOLS-1:0] sink_data;
   logic [`ST_CHANNEL_W-1:0]                sink_channel;
   logic                                    sink_valid;
   logic                                    sink_startofpacket;
   logic                                    sink_endofpacket;
   logic [`ST_ERROR_W-1:0]                  sink_error;
   logic [`ST_EMPTY_W-1:0]                  sink_empty;
   logic                                    sink_ready;
   logic                                    psel;
   logic                                    penable;
   logic                                    pwrite;
   logic [`APB_ADDR_W-1:0]                  paddr;
   logic [31:0]                             pwdata;
   logic [31:0]                             prdata;
   logic                                    pready;
   logic                                    pslverr;

   // reference model state
   st_txn_t               exp_q[$];
   st_txn_t               mon_rec;
   logic [`ST_IDLE_W-1:0] idle_ref;
   logic                  ready_prev;
   logic                  qual_ready;
   logic [31:0]           lcg_state = 32'd65;

   int data_errors   = 0;
   int header_errors = 0;
   int status_errors = 0;
   int flag_errors   = 0;
   int other_errors  = 0;

   st_capture_top i_dut (
      .clk                (clk),
      .reset              (reset),
      .sink_data          (sink_data),
      .sink_channel       (sink_channel),
      .sink_valid         (sink_valid),
      .sink_startofpacket (sink_startofpacket),
      .sink_endofpacket   (sink_endofpacket),
      .sink_error         (sink_error),
      .sink_empty         (sink_empty),
      .sink_ready         (sink_ready),
      .psel               (psel),
      .penable            (penable),
      .pwrite             (pwrite),
      .paddr              (paddr),
      .pwdata             (pwdata),
      .prdata             (prdata),
      .pready             (pready),
      .pslverr            (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // header layout from msb is idles, channel, error, empty, sop and eop
   function automatic st_header_u ref_header(input logic [`ST_IDLE_W-1:0] idles,
                                             input logic [`ST_CHANNEL_W-1:0] channel,
                                             input logic [`ST_ERROR_W-1:0] error,
                                             input logic [`ST_EMPTY_W-1:0] empty,
                                             input logic sop,
                                             input logic eop);
      st_header_u h;
      h.raw = {idles, channel, error, empty, sop, eop};
      return h;
   endfunction

   function automatic st_status_t expected_status(input int level);
      st_status_t s;
      s       = '0;
      s.level = level;
      s.empty = (level == 0);
      s.full  = (level == `TXN_DEPTH);
      return s;
   endfunction

   // sink handshake as seen by the source side
   assign qual_ready = (`ST_READY_LATENCY == 0) ? sink_ready : ready_prev;

   // records every taken beat and counts ready cycles with nothing offered
   always @(posedge clk) begin
      if (reset) begin
         idle_ref = '0;
         ready_prev <= 1'b0;
         exp_q.delete();
      end else begin
         ready_prev <= sink_ready;
         if (sink_valid && qual_ready) begin
            mon_rec.data   = sink_data;
            mon_rec.header = ref_header(idle_ref, sink_channel, sink_error, sink_empty,
                                        sink_startofpacket, sink_endofpacket);
            exp_q.push_back(mon_rec);
            idle_ref = '0;
         end else if (qual_ready && (idle_ref != '1)) begin
            idle_ref = idle_ref + 1'b1;
         end
      end
   end

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------

   task automatic check_data(input string name, input st_data_t exp, input st_data_t act);
      if (act !== exp) begin
         data_errors++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_header(input string name, input st_header_u exp, input st_header_u act);
      if (act.raw !== exp.raw) begin
         header_errors++;
         $display("Error %s: expected %h, actual %h", name, exp.raw, act.raw);
      end
   endtask

   task automatic check_status(input string name, input st_status_t exp, input st_status_t act);
      if (act !== exp) begin
         status_errors++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         flag_errors++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // --------------------------------------------------
   // apb master
   // --------------------------------------------------

   // response is taken at the access edge that follows the setup phase
   task automatic apb_xfer(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      rdata = prdata;
      err   = pslverr;
      if (pready !== 1'b1) begin
         other_errors++;
         $display("pready was not high in the access cycle to address %h", addr);
      end
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] rdata,
                           output logic err);
      apb_xfer(1'b0, addr, 32'h0, rdata, err);
   endtask

   task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] wdata,
                            output logic err);
      logic [31:0] unused;
      apb_xfer(1'b1, addr, wdata, unused, err);
   endtask

   // --------------------------------------------------
   // sink stimulus and draining
   // --------------------------------------------------

   task automatic load_random_beat();
      logic [31:0] r;
      sink_data          = lcg_next();
      r                  = lcg_next();
      sink_channel       = r[31:24];
      sink_error         = r[23:20];
      sink_empty         = r[19:18];
      sink_startofpacket = r[17];
      sink_endofpacket   = r[16];
      sink_valid         = 1'b1;
   endtask

   // each beat is held until taken and followed by a random number of idle cycles
   task automatic send_beats(input int n, input int max_gap);
      int gap;
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         load_random_beat();
         @(posedge clk);
         while (!qual_ready) @(posedge clk);
         gap = (max_gap == 0) ? 0 : int'((lcg_next() >> 16) % (max_gap + 1));
         if (gap != 0) begin
            @(negedge clk);
            sink_valid = 1'b0;
            repeat (gap - 1) @(negedge clk);
         end
      end
      @(negedge clk);
      sink_valid = 1'b0;
   endtask

   task automatic pop_and_compare(input string name);
      st_txn_t     exp;
      logic [31:0] word;
      logic        err;
      exp = exp_q.pop_front();
      apb_read(REG_DATA, word, err);
      check_data({name, " data"}, exp.data, word);
      check_flag({name, " read pslverr"}, 1'b0, err);
      apb_read(REG_HEADER, word, err);
      check_header({name, " header"}, exp.header, word);
      apb_write(REG_POP, 32'h0, err);
      check_flag({name, " pop pslverr"}, 1'b0, err);
   endtask

   task automatic drain_and_compare(input int n, input string name);
      for (int i = 0; i < n; i++) begin
         while (exp_q.size() == 0) @(negedge clk);
         pop_and_compare(name);
      end
   endtask

   // queue fills and holds before draining through the hysteresis
   task automatic backpressure_drain(input int n);
      logic [31:0] word;
      logic        err;
      int          popped;
      popped = 0;
      while (sink_ready) @(negedge clk);
      repeat (3) @(negedge clk);
      check_flag("backpressure ready low", 1'b0, sink_ready);
      if (exp_q.size() > `TXN_DEPTH) begin
         other_errors++;
         $display("queue took %0d beats, more than its depth", exp_q.size());
      end
      apb_read(REG_STATUS, word, err);
      check_status("backpressure status", expected_status(exp_q.size()), word);
      while (exp_q.size() > `TXN_LO_MARK) begin
         pop_and_compare("backpressure");
         popped++;
      end
      @(negedge clk);
      check_flag("ready back at low mark", 1'b1, sink_ready);
      drain_and_compare(n - popped, "backpressure");
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------

   initial begin
      logic [31:0] word;
      logic        err;
      reset              = 1'b1;
      sink_data          = '0;
      sink_channel       = '0;
      sink_valid         = 1'b0;
      sink_startofpacket = 1'b0;
      sink_endofpacket   = 1'b0;
      sink_error         = '0;
      sink_empty         = '0;
      psel               = 1'b0;
      penable            = 1'b0;
      pwrite             = 1'b0;
      paddr              = '0;
      pwdata             = '0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // after reset
      check_flag("reset sink_ready", 1'b0, sink_ready);
      check_flag("reset pready", 1'b0, pready);
      check_flag("reset pslverr", 1'b0, pslverr);
      check_data("reset prdata", '0, prdata);
      apb_read(REG_STATUS, word, err);
      check_status("reset status", expected_status(0), word);
      apb_read(REG_DATA, word, err);
      check_data("reset data", '0, word);

      // random beats popped one at a time
      apb_write(REG_CTRL, 32'h1, err);
      @(negedge clk);
      check_flag("ready after enable", 1'b1, sink_ready);
      fork
         send_beats(40, MAX_GAP);
         drain_and_compare(40, "random beats");
      join

      // back-pressure without popping
      fork
         send_beats(20, 0);
         backpressure_drain(20);
      join

      // an offered beat must be ignored once ready_en is cleared
      send_beats(2, 0);
      apb_write(REG_CTRL, 32'h0, err);
      @(negedge clk);
      check_flag("ready after disable", 1'b0, sink_ready);
      load_random_beat();
      repeat (10) @(negedge clk);
      sink_valid = 1'b0;
      apb_read(REG_STATUS, word, err);
      check_status("disabled status", expected_status(2), word);
      if (exp_q.size() != 2) begin
         other_errors++;
         $display("a beat was captured while ready_en was clear");
      end
      drain_and_compare(exp_q.size(), "disabled");

      // slave error responses
      apb_read(8'h14, word, err);
      check_flag("unmapped read pslverr", 1'b1, err);
      apb_write(REG_STATUS, 32'h0, err);
      check_flag("status write pslverr", 1'b1, err);
      apb_write(REG_POP, 32'h0, err);
      check_flag("empty pop pslverr", 1'b1, err);
      apb_read(REG_STATUS, word, err);
      check_flag("status read pslverr", 1'b0, err);
      check_status("final status", expected_status(0), word);
      apb_write(REG_CTRL, 32'h0, err);
      check_flag("ctrl write pslverr", 1'b0, err);
      apb_read(REG_DATA, word, err);
      check_flag("empty data read pslverr", 1'b0, err);
      check_data("empty data read", '0, word);

      $display("errors: data %0d, header %0d, status %0d, flag %0d, other %0d",
               data_errors, header_errors, status_errors, flag_errors, other_errors);
      if (data_errors + header_errors + status_errors + flag_errors + other_errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // stops a hung run
   initial begin
      #(WATCHDOG_LIMIT);
      $display("watchdog expired after %0d time units, the run did not finish", WATCHDOG_LIMIT);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/st_stream_pkg.sv
rtl/st_apb_pkg.sv
rtl/st_txn_if.sv
rtl/st_ready_fsm.sv
rtl/st_idle_counter.sv
rtl/st_txn_queue.sv
rtl/st_apb_regs.sv
rtl/st_capture_top.sv
sim/st_capture_tb.sv

// ==== Bender.yml ====
package:
  name: st_capture

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/st_stream_pkg.sv
      - rtl/st_apb_pkg.sv
      - rtl/st_txn_if.sv
      - rtl/st_ready_fsm.sv
      - rtl/st_idle_counter.sv
      - rtl/st_txn_queue.sv
      - rtl/st_apb_regs.sv
      - rtl/st_capture_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/st_capture_tb.sv
